//--- logic/rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

    // ALU operation codes, SLA (4'b1010) is not selectable
    typedef enum logic [3:0] {
        ALU_ADD    = 4'b0000,
        ALU_SUB    = 4'b0001,
        ALU_AND    = 4'b0010,
        ALU_OR     = 4'b0011,
        ALU_SLL    = 4'b0100,
        ALU_SLT    = 4'b0101,
        ALU_SLTU   = 4'b0110,
        ALU_SRL    = 4'b0111,
        ALU_XOR    = 4'b1000,
        ALU_SRA    = 4'b1001,
        ALU_PASS_B = 4'b1111
    } alu_ctrl_e;

    typedef enum logic [2:0] {
        BR_EQ   = 3'b000,
        BR_NE   = 3'b001,
        BR_LT   = 3'b010,
        BR_GE   = 3'b011,
        BR_LTU  = 3'b100,
        BR_GEU  = 3'b101,
        BR_NONE = 3'b111
    } branch_ctrl_e;

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;

    // OP / OP-IMM funct3
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    // branch funct3
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;

endpackage

`default_nettype wire

//--- logic/exec_cfg_pkg.sv
`default_nettype none

package exec_cfg_pkg;

    localparam int XLEN        = 32;
    localparam int SHIFT_WIDTH = 5;

    // instruction queue depth, also the upstream credit count
    localparam int IN_DEPTH    = 4;
    localparam int OUT_CREDITS = 4;

    typedef struct packed {
        logic [4:0]      rd;
        logic [XLEN-1:0] value;
        logic            taken;
        logic            illegal;
    } exec_result_t;

endpackage

`default_nettype wire

//--- logic/decode_if.sv
`default_nettype none

interface decode_if;
    import rv_isa_pkg::*;
    import exec_cfg_pkg::*;

    alu_ctrl_e       alu_ctrl;
    branch_ctrl_e    branch_ctrl;
    logic [4:0]      rs1;
    logic [4:0]      rs2;
    logic [4:0]      rd;
    logic [XLEN-1:0] imm;
    logic            use_imm;
    logic            wr_en;
    logic            is_branch;
    logic            illegal;

    modport dec (
        output alu_ctrl, branch_ctrl, rs1, rs2, rd, imm,
        output use_imm, wr_en, is_branch, illegal
    );

    modport exe (
        input alu_ctrl, branch_ctrl, rs1, rs2, rd, imm,
        input use_imm, wr_en, is_branch, illegal
    );

endinterface

`default_nettype wire

//--- logic/credit_fifo.sv
`default_nettype none

module credit_fifo #(
    parameter type payload_t = logic [31:0],
    parameter int  DEPTH     = 4
) (
    input  wire logic clk_i,
    input  wire logic arst_n_i,
    input  wire logic push_i,
    input  payload_t  push_data_i,
    input  wire logic pop_i,
    output payload_t  head_o,
    output logic      not_empty_o,
    output logic      credit_o
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t         mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    assign head_o      = mem[rd_ptr];
    assign not_empty_o = (count != '0);

    always_ff @(posedge clk_i) begin
        if (push_i) begin
            mem[wr_ptr] <= push_data_i;
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            credit_o <= 1'b0;
        end else begin
            if (push_i) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop_i) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count    <= count + CNT_W'(push_i) - CNT_W'(pop_i);
            // one credit back per entry leaving
            credit_o <= pop_i;
        end
    end

endmodule

`default_nettype wire

//--- logic/alu.sv
`default_nettype none

module alu #(
    parameter int XLEN        = 32,
    parameter int SHIFT_WIDTH = 5
) (
    input  wire logic [XLEN-1:0]     src_a_i,
    input  wire logic [XLEN-1:0]     src_b_i,
    input  rv_isa_pkg::alu_ctrl_e    alu_ctrl_i,
    input  rv_isa_pkg::branch_ctrl_e branch_ctrl_i,
    output logic [XLEN-1:0]          result_o,
    output logic                     branch_o
);
    import rv_isa_pkg::*;

    logic signed [XLEN-1:0]  src_a_s;
    logic signed [XLEN-1:0]  src_b_s;
    logic [SHIFT_WIDTH-1:0]  shamt;
    logic                    lt_s;
    logic                    lt_u;

    assign src_a_s = src_a_i;
    assign src_b_s = src_b_i;
    assign shamt   = src_b_i[SHIFT_WIDTH-1:0];

    // shared by slt/sltu and the branch compares
    assign lt_s = (src_a_s < src_b_s);
    assign lt_u = (src_a_i < src_b_i);

    always_comb begin
        case (branch_ctrl_i)
            BR_EQ:   branch_o = (src_a_i == src_b_i);
            BR_NE:   branch_o = (src_a_i != src_b_i);
            BR_LT:   branch_o = lt_s;
            BR_GE:   branch_o = !lt_s;
            BR_LTU:  branch_o = lt_u;
            BR_GEU:  branch_o = !lt_u;
            default: branch_o = 1'b0;
        endcase
    end

    always_comb begin
        case (alu_ctrl_i)
            ALU_ADD:    result_o = src_a_i + src_b_i;
            ALU_SUB:    result_o = src_a_i - src_b_i;
            ALU_AND:    result_o = src_a_i & src_b_i;
            ALU_OR:     result_o = src_a_i | src_b_i;
            ALU_XOR:    result_o = src_a_i ^ src_b_i;
            ALU_SLT:    result_o = XLEN'(lt_s);
            ALU_SLTU:   result_o = XLEN'(lt_u);
            ALU_SLL:    result_o = src_a_i << shamt;
            ALU_SRL:    result_o = src_a_i >> shamt;
            // arithmetic shift keeps the sign
            ALU_SRA:    result_o = src_a_s >>> shamt;
            ALU_PASS_B: result_o = src_b_i;
            default:    result_o = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- logic/instr_decoder.sv
`default_nettype none

module instr_decoder (
    input wire logic [31:0] instr_i,
    decode_if.dec           dec
);
    import rv_isa_pkg::*;
    import exec_cfg_pkg::*;

    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic [6:0]      funct7;
    logic            is_imm;
    logic            f7_ok;
    alu_ctrl_e       arith_op;
    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm_u;
    logic [XLEN-1:0] imm_b;

    assign opcode = instr_i[6:0];
    assign funct3 = instr_i[14:12];
    assign funct7 = instr_i[31:25];
    assign is_imm = (opcode == OPC_OP_IMM);

    assign imm_i = XLEN'(signed'(instr_i[31:20]));
    assign imm_u = XLEN'(signed'({instr_i[31:12], 12'h000}));
    assign imm_b = XLEN'(signed'({instr_i[31], instr_i[7], instr_i[30:25],
                                  instr_i[11:8], 1'b0}));

    // funct3 plus funct7 to an ALU op, shared by OP and OP-IMM
    always_comb begin
        arith_op = ALU_ADD;
        f7_ok    = 1'b0;
        case (funct3)
            F3_ADD_SUB: begin
                arith_op = (!is_imm && funct7 == F7_ALT) ? ALU_SUB : ALU_ADD;
                f7_ok    = is_imm || funct7 == F7_BASE || funct7 == F7_ALT;
            end
            F3_SLL: begin
                arith_op = ALU_SLL;
                f7_ok    = (funct7 == F7_BASE);
            end
            F3_SLT: begin
                arith_op = ALU_SLT;
                f7_ok    = is_imm || funct7 == F7_BASE;
            end
            F3_SLTU: begin
                arith_op = ALU_SLTU;
                f7_ok    = is_imm || funct7 == F7_BASE;
            end
            F3_XOR: begin
                arith_op = ALU_XOR;
                f7_ok    = is_imm || funct7 == F7_BASE;
            end
            F3_SRL_SRA: begin
                // shift immediates keep funct7 in the upper imm bits
                arith_op = (funct7 == F7_ALT) ? ALU_SRA : ALU_SRL;
                f7_ok    = (funct7 == F7_BASE) || (funct7 == F7_ALT);
            end
            F3_OR: begin
                arith_op = ALU_OR;
                f7_ok    = is_imm || funct7 == F7_BASE;
            end
            default: begin
                arith_op = ALU_AND;
                f7_ok    = is_imm || funct7 == F7_BASE;
            end
        endcase
    end

    always_comb begin
        dec.alu_ctrl    = ALU_ADD;
        dec.branch_ctrl = BR_NONE;
        dec.rs1         = instr_i[19:15];
        dec.rs2         = instr_i[24:20];
        dec.rd          = 5'd0;
        dec.imm         = imm_i;
        dec.use_imm     = 1'b0;
        dec.wr_en       = 1'b0;
        dec.is_branch   = 1'b0;
        dec.illegal     = 1'b0;
        case (opcode)
            OPC_OP, OPC_OP_IMM: begin
                dec.alu_ctrl = arith_op;
                dec.use_imm  = is_imm;
                dec.rd       = instr_i[11:7];
                dec.wr_en    = f7_ok;
                dec.illegal  = !f7_ok;
            end
            OPC_LUI: begin
                dec.alu_ctrl = ALU_PASS_B;
                dec.imm      = imm_u;
                dec.use_imm  = 1'b1;
                dec.rd       = instr_i[11:7];
                dec.wr_en    = 1'b1;
            end
            OPC_BRANCH: begin
                dec.alu_ctrl  = ALU_SUB;
                dec.imm       = imm_b;
                dec.is_branch = 1'b1;
                case (funct3)
                    F3_BEQ:  dec.branch_ctrl = BR_EQ;
                    F3_BNE:  dec.branch_ctrl = BR_NE;
                    F3_BLT:  dec.branch_ctrl = BR_LT;
                    F3_BGE:  dec.branch_ctrl = BR_GE;
                    F3_BLTU: dec.branch_ctrl = BR_LTU;
                    F3_BGEU: dec.branch_ctrl = BR_GEU;
                    default: dec.illegal     = 1'b1;
                endcase
            end
            default: dec.illegal = 1'b1;
        endcase
    end

endmodule

`default_nettype wire

//--- logic/reg_file.sv
`default_nettype none

module reg_file #(
    parameter int XLEN = 32
) (
    input  wire logic            clk_i,
    input  wire logic            arst_n_i,
    input  wire logic [4:0]      rs1_i,
    input  wire logic [4:0]      rs2_i,
    output logic [XLEN-1:0]      rd1_o,
    output logic [XLEN-1:0]      rd2_o,
    input  wire logic            we_i,
    input  wire logic [4:0]      wa_i,
    input  wire logic [XLEN-1:0] wd_i
);

    logic [XLEN-1:0] regs [32];

    assign rd1_o = regs[rs1_i];
    assign rd2_o = regs[rs2_i];

    // x0 is never written, so it stays at its reset value
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            regs <= '{default: '0};
        end else if (we_i && wa_i != 5'd0) begin
            regs[wa_i] <= wd_i;
        end
    end

endmodule

`default_nettype wire

//--- logic/exec_stage.sv
`default_nettype none

module exec_stage #(
    parameter int XLEN        = exec_cfg_pkg::XLEN,
    parameter int OUT_CREDITS = exec_cfg_pkg::OUT_CREDITS
) (
    input  wire logic                 clk_i,
    input  wire logic                 arst_n_i,
    decode_if.exe                     dec,
    input  wire logic                 head_valid_i,
    output logic                      pop_o,
    output logic [4:0]                rs1_o,
    output logic [4:0]                rs2_o,
    input  wire logic [XLEN-1:0]      rd1_i,
    input  wire logic [XLEN-1:0]      rd2_i,
    output logic                      we_o,
    output logic [4:0]                wa_o,
    output logic [XLEN-1:0]           wd_o,
    input  wire logic                 out_credit_i,
    output logic                      out_valid_o,
    output exec_cfg_pkg::exec_result_t out_result_o
);

    localparam int CNT_W = $clog2(OUT_CREDITS + 1);

    logic [CNT_W-1:0] credit_cnt;
    logic             issue;
    logic             writes;
    logic [XLEN-1:0]  src_b;
    logic [XLEN-1:0]  alu_result;
    logic             taken;

    assign issue  = head_valid_i && (credit_cnt != '0);
    assign writes = dec.wr_en && !dec.is_branch && !dec.illegal;
    assign pop_o  = issue;

    assign rs1_o = dec.rs1;
    assign rs2_o = dec.rs2;
    assign src_b = dec.use_imm ? dec.imm : rd2_i;

    alu #(
        .XLEN        (XLEN),
        .SHIFT_WIDTH ($clog2(XLEN))
    ) u_alu (
        .src_a_i       (rd1_i),
        .src_b_i       (src_b),
        .alu_ctrl_i    (dec.alu_ctrl),
        .branch_ctrl_i (dec.branch_ctrl),
        .result_o      (alu_result),
        .branch_o      (taken)
    );

    // write-back lands on the issue edge
    assign we_o = issue && writes;
    assign wa_o = dec.rd;
    assign wd_o = alu_result;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            credit_cnt  <= CNT_W'(OUT_CREDITS);
            out_valid_o <= 1'b0;
        end else begin
            credit_cnt  <= credit_cnt + CNT_W'(out_credit_i) - CNT_W'(issue);
            out_valid_o <= issue;
        end
    end

    always_ff @(posedge clk_i) begin
        if (issue) begin
            out_result_o.rd      <= writes ? dec.rd : 5'd0;
            out_result_o.value   <= dec.illegal ? '0 : alu_result;
            out_result_o.taken   <= dec.is_branch && taken;
            out_result_o.illegal <= dec.illegal;
        end
    end

endmodule

`default_nettype wire

//--- logic/rv_exec_top.sv
`default_nettype none

module rv_exec_top #(
    parameter int IN_DEPTH    = exec_cfg_pkg::IN_DEPTH,
    parameter int OUT_CREDITS = exec_cfg_pkg::OUT_CREDITS
) (
    input  wire logic                          clk_i,
    input  wire logic                          arst_n_i,
    input  wire logic                          in_valid_i,
    input  wire logic [31:0]                   in_instr_i,
    output logic                               in_credit_o,
    input  wire logic                          out_credit_i,
    output logic                               out_valid_o,
    output logic [4:0]                         out_rd_o,
    output logic [exec_cfg_pkg::XLEN-1:0]      out_value_o,
    output logic                               out_taken_o,
    output logic                               out_illegal_o
);
    import exec_cfg_pkg::*;

    logic [31:0]     head_instr;
    logic            head_valid;
    logic            pop;
    logic [4:0]      rs1;
    logic [4:0]      rs2;
    logic [XLEN-1:0] rd1;
    logic [XLEN-1:0] rd2;
    logic            we;
    logic [4:0]      wa;
    logic [XLEN-1:0] wd;
    exec_result_t    out_result;

    decode_if dec_bus ();

    credit_fifo #(
        .payload_t (logic [31:0]),
        .DEPTH     (IN_DEPTH)
    ) u_in_queue (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .push_i      (in_valid_i),
        .push_data_i (in_instr_i),
        .pop_i       (pop),
        .head_o      (head_instr),
        .not_empty_o (head_valid),
        .credit_o    (in_credit_o)
    );

    instr_decoder u_decoder (
        .instr_i (head_instr),
        .dec     (dec_bus.dec)
    );

    reg_file #(
        .XLEN (XLEN)
    ) u_regs (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .rs1_i    (rs1),
        .rs2_i    (rs2),
        .rd1_o    (rd1),
        .rd2_o    (rd2),
        .we_i     (we),
        .wa_i     (wa),
        .wd_i     (wd)
    );

    exec_stage #(
        .XLEN        (XLEN),
        .OUT_CREDITS (OUT_CREDITS)
    ) u_exec (
        .clk_i        (clk_i),
        .arst_n_i     (arst_n_i),
        .dec          (dec_bus.exe),
        .head_valid_i (head_valid),
        .pop_o        (pop),
        .rs1_o        (rs1),
        .rs2_o        (rs2),
        .rd1_i        (rd1),
        .rd2_i        (rd2),
        .we_o         (we),
        .wa_o         (wa),
        .wd_o         (wd),
        .out_credit_i (out_credit_i),
        .out_valid_o  (out_valid_o),
        .out_result_o (out_result)
    );

    // record split onto the plain output ports
    assign out_rd_o      = out_result.rd;
    assign out_value_o   = out_result.value;
    assign out_taken_o   = out_result.taken;
    assign out_illegal_o = out_result.illegal;

endmodule

`default_nettype wire

//--- test/tb_clock.sv
`default_nettype none

module tb_clock #(
    parameter int PERIOD = 20
) (
    output logic clk_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD / 2) clk_o = ~clk_o;
    end

endmodule

`default_nettype wire

//--- test/rv_exec_assert.sv
`default_nettype none

module rv_exec_assert #(
    parameter int OUT_CREDITS = 4,
    parameter int CNT_W       = 3
) (
    input wire logic             clk_i,
    input wire logic             arst_n_i,
    input wire logic [CNT_W-1:0] credit_cnt_i,
    input wire logic             out_credit_i,
    input wire logic             out_valid_i,
    input wire logic             pop_i,
    input wire logic             head_valid_i
);

    // credits left as seen on the output link alone
    int sends_left;
    int free_credits;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            sends_left <= OUT_CREDITS;
        end else begin
            sends_left <= sends_left + int'(out_credit_i) - int'(out_valid_i);
        end
    end

    // a record on the link now was paid for at its issue edge
    assign free_credits = sends_left - int'(out_valid_i);

    credit_limit: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        credit_cnt_i <= CNT_W'(OUT_CREDITS))
        else $error("output credit count above its reset value");

    // nothing may be sent with no credit left and none coming back
    no_send_without_credit: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        (free_credits == 0 && !out_credit_i) |=> !out_valid_i)
        else $error("record sent without an output credit");

    pop_needs_entry: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        pop_i |-> (head_valid_i && free_credits > 0))
        else $error("queue popped while empty or without an output credit");

endmodule

bind exec_stage rv_exec_assert #(
    .OUT_CREDITS (OUT_CREDITS),
    .CNT_W       (CNT_W)
) u_credit_assert (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .credit_cnt_i (credit_cnt),
    .out_credit_i (out_credit_i),
    .out_valid_i  (out_valid_o),
    .pop_i        (pop_o),
    .head_valid_i (head_valid_i)
);

`default_nettype wire

//--- test/rv_exec_tb.sv
`default_nettype none

module rv_exec_tb;
    import rv_isa_pkg::*;
    import exec_cfg_pkg::*;

    localparam int NUM_INSTR     = 2000;
    localparam int CLK_PERIOD    = 20;
    localparam int WATCHDOG_TIME = NUM_INSTR * 40 * CLK_PERIOD;

    logic            clk;
    logic            arst_n;
    logic            in_valid;
    logic [31:0]     in_instr;
    logic            in_credit;
    logic            out_credit;
    logic            out_valid;
    logic [4:0]      out_rd;
    logic [XLEN-1:0] out_value;
    logic            out_taken;
    logic            out_illegal;

    logic [31:0]     rng_state;
    logic [XLEN-1:0] model_regs [32];
    exec_result_t    exp_q [$];
    int              in_credits;
    int              sent;
    int              records;
    int              returned;
    int              owed;
    int              hold;
    int              credit_pulses;
    int              errors;

    tb_clock #(
        .PERIOD (CLK_PERIOD)
    ) u_clock (
        .clk_o (clk)
    );

    rv_exec_top #(
        .IN_DEPTH    (IN_DEPTH),
        .OUT_CREDITS (OUT_CREDITS)
    ) dut (
        .clk_i         (clk),
        .arst_n_i      (arst_n),
        .in_valid_i    (in_valid),
        .in_instr_i    (in_instr),
        .in_credit_o   (in_credit),
        .out_credit_i  (out_credit),
        .out_valid_o   (out_valid),
        .out_rd_o      (out_rd),
        .out_value_o   (out_value),
        .out_taken_o   (out_taken),
        .out_illegal_o (out_illegal)
    );

    function automatic logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // only x0..x7 so that dependencies come often
    function automatic logic [31:0] gen_instr();
        logic [31:0] r;
        logic [31:0] s;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [31:0] instr;
        r   = next_rand();
        s   = next_rand();
        rd  = {2'b00, s[2:0]};
        rs1 = {2'b00, s[5:3]};
        rs2 = {2'b00, s[8:6]};
        f3  = s[11:9];
        case (r[3:0])
            4'd5, 4'd6, 4'd7, 4'd8: begin
                f7 = r[31:25];
                if (f3 == F3_SLL) begin
                    f7 = F7_BASE;
                end else if (f3 == F3_SRL_SRA) begin
                    f7 = s[12] ? F7_ALT : F7_BASE;
                end
                instr = {f7, r[24:20], rs1, f3, rd, OPC_OP_IMM};
            end
            4'd9, 4'd10: instr = {r[31:12], rd, OPC_LUI};
            4'd11, 4'd12, 4'd13: begin
                case (f3)
                    3'd0, 3'd6: f3 = F3_BEQ;
                    3'd1, 3'd7: f3 = F3_BNE;
                    3'd2:       f3 = F3_BLT;
                    3'd3:       f3 = F3_BGE;
                    3'd4:       f3 = F3_BLTU;
                    default:    f3 = F3_BGEU;
                endcase
                instr = {r[31:25], rs2, rs1, f3, r[11:7], OPC_BRANCH};
            end
            4'd14: begin
                // undefined encodings of several kinds
                case (s[14:13])
                    2'd0:    instr = {7'b0000001, rs2, rs1, f3, rd, OPC_OP};
                    2'd1:    instr = {r[31:25], rs2, rs1, 2'b01, s[12], r[11:7], OPC_BRANCH};
                    2'd2:    instr = {7'b0000100, r[24:20], rs1, F3_SLL, rd, OPC_OP_IMM};
                    default: instr = {r[31:7], 7'b0000011};
                endcase
            end
            default: begin
                f7 = ((f3 == F3_ADD_SUB || f3 == F3_SRL_SRA) && s[12]) ? F7_ALT : F7_BASE;
                instr = {f7, rs2, rs1, f3, rd, OPC_OP};
            end
        endcase
        return instr;
    endfunction

    function automatic logic [XLEN-1:0] arith(input logic [2:0] f3, input logic alt,
                                              input logic [XLEN-1:0] a,
                                              input logic [XLEN-1:0] b);
        logic signed [XLEN-1:0] sa;
        logic signed [XLEN-1:0] sb;
        sa = a;
        sb = b;
        case (f3)
            F3_ADD_SUB: return alt ? a - b : a + b;
            F3_SLL:     return a << b[4:0];
            F3_SLT:     return XLEN'(sa < sb);
            F3_SLTU:    return XLEN'(a < b);
            F3_XOR:     return a ^ b;
            F3_SRL_SRA: begin
                if (alt) begin
                    return sa >>> b[4:0];
                end
                return a >> b[4:0];
            end
            F3_OR:      return a | b;
            default:    return a & b;
        endcase
    endfunction

    function automatic logic branch_taken(input logic [2:0] f3, input logic [XLEN-1:0] a,
                                          input logic [XLEN-1:0] b);
        logic signed [XLEN-1:0] sa;
        logic signed [XLEN-1:0] sb;
        sa = a;
        sb = b;
        case (f3)
            F3_BEQ:  return a == b;
            F3_BNE:  return a != b;
            F3_BLT:  return sa < sb;
            F3_BGE:  return sa >= sb;
            F3_BLTU: return a < b;
            default: return a >= b;
        endcase
    endfunction

    // in-order ISA model with its own register file
    function automatic exec_result_t predict(input logic [31:0] instr);
        exec_result_t    rec;
        logic [6:0]      opc;
        logic [2:0]      f3;
        logic [6:0]      f7;
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        logic            legal;
        logic            alt;
        opc   = instr[6:0];
        f3    = instr[14:12];
        f7    = instr[31:25];
        a     = model_regs[instr[19:15]];
        b     = model_regs[instr[24:20]];
        rec   = '0;
        legal = 1'b1;
        case (opc)
            OPC_OP, OPC_OP_IMM: begin
                alt = (f7 == F7_ALT);
                if (opc == OPC_OP) begin
                    legal = (f7 == F7_BASE) || (alt && (f3 == F3_ADD_SUB || f3 == F3_SRL_SRA));
                end else begin
                    b = {{20{instr[31]}}, instr[31:20]};
                    if (f3 == F3_SLL) begin
                        legal = (f7 == F7_BASE);
                    end else if (f3 == F3_SRL_SRA) begin
                        legal = (f7 == F7_BASE) || alt;
                    end
                    // there is no subi
                    if (f3 == F3_ADD_SUB) begin
                        alt = 1'b0;
                    end
                end
                if (legal) begin
                    rec.rd    = instr[11:7];
                    rec.value = arith(f3, alt, a, b);
                end else begin
                    rec.illegal = 1'b1;
                end
            end
            OPC_LUI: begin
                rec.rd    = instr[11:7];
                rec.value = {instr[31:12], 12'h000};
            end
            OPC_BRANCH: begin
                if (f3 == 3'b010 || f3 == 3'b011) begin
                    rec.illegal = 1'b1;
                end else begin
                    rec.value = a - b;
                    rec.taken = branch_taken(f3, a, b);
                end
            end
            default: rec.illegal = 1'b1;
        endcase
        if (rec.rd != 5'd0) begin
            model_regs[rec.rd] = rec.value;
        end
        return rec;
    endfunction

    task automatic check_value(input string name, input logic [XLEN-1:0] got,
                               input logic [XLEN-1:0] expected);
        if (got !== expected) begin
            errors++;
            $display("[ERROR] %s: got 0x%08h, expected 0x%08h", name, got, expected);
            $display("Checks failed");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    task automatic abort_run(input string why);
        errors++;
        $display("%s", why);
        $display("Checks failed");
        $fatal(1, "stopping on protocol error");
    endtask

    task automatic collect_outputs();
        exec_result_t expected;
        if (in_credit) begin
            in_credits++;
            credit_pulses++;
            if (in_credits > IN_DEPTH) begin
                abort_run("more input credits returned than beats sent");
            end
        end
        if (out_valid) begin
            if (exp_q.size() == 0) begin
                abort_run("a record arrived with no instruction outstanding");
            end
            expected = exp_q.pop_front();
            records++;
            if (records > OUT_CREDITS + returned) begin
                abort_run("more records sent than output credits allow");
            end
            owed++;
            check_value("out_rd_o", XLEN'(out_rd), XLEN'(expected.rd));
            check_value("out_value_o", out_value, expected.value);
            check_value("out_taken_o", XLEN'(out_taken), XLEN'(expected.taken));
            check_value("out_illegal_o", XLEN'(out_illegal), XLEN'(expected.illegal));
        end
    endtask

    // random return delays and long stretches with no returns
    task automatic drive_credit_return();
        logic [31:0] r;
        r          = next_rand();
        out_credit = 1'b0;
        if (hold > 0) begin
            hold--;
        end else if (r[5:0] == 6'd0) begin
            hold = 40 + int'(r[11:6]);
        end else if (owed > 0 && r[7:6] != 2'b00) begin
            out_credit = 1'b1;
            owed--;
            returned++;
        end
    endtask

    task automatic drive_instr();
        logic [31:0] r;
        logic [31:0] instr;
        r        = next_rand();
        in_valid = 1'b0;
        if (sent < NUM_INSTR && in_credits > 0 && r[1:0] != 2'b00) begin
            instr = gen_instr();
            exp_q.push_back(predict(instr));
            in_instr = instr;
            in_valid = 1'b1;
            in_credits--;
            sent++;
        end
    endtask

    initial begin
        rng_state     = 32'hd64df864;
        arst_n        = 1'b0;
        in_valid      = 1'b0;
        in_instr      = '0;
        out_credit    = 1'b0;
        in_credits    = IN_DEPTH;
        sent          = 0;
        records       = 0;
        returned      = 0;
        owed          = 0;
        hold          = 0;
        credit_pulses = 0;
        errors        = 0;
        foreach (model_regs[i]) begin
            model_regs[i] = '0;
        end
        repeat (4) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        while (sent < NUM_INSTR || exp_q.size() != 0) begin
            @(negedge clk);
            collect_outputs();
            drive_credit_return();
            drive_instr();
        end
        // last credit pulse comes with the last record
        check_value("in_credit_o pulses", XLEN'(credit_pulses), XLEN'(NUM_INSTR));
        if (errors == 0) begin
            $display("All checks passed");
            $finish;
        end else begin
            $display("Checks failed");
            $fatal(1, "errors counted at end of run");
        end
    end

    initial begin
        #(WATCHDOG_TIME);
        $display("timeout: the run did not drain within the time limit");
        $display("Checks failed");
        $fatal(1, "watchdog expired");
    end

endmodule

`default_nettype wire

//--- filelist.f
logic/rv_isa_pkg.sv
logic/exec_cfg_pkg.sv
logic/decode_if.sv
logic/credit_fifo.sv
logic/alu.sv
logic/instr_decoder.sv
logic/reg_file.sv
logic/exec_stage.sv
logic/rv_exec_top.sv
test/tb_clock.sv
test/rv_exec_assert.sv
test/rv_exec_tb.sv

//--- run_sim.sh
#!/bin/sh
# compile and run the rv_exec testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f filelist.f \
    --top-module rv_exec_tb -o rv_exec_sim
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

./obj_dir/rv_exec_sim > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "Checks failed" "$LOG"; then
    echo "FAIL"
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "FAIL: simulator exited with status $status"
    exit 1
fi
echo "PASS"
exit 0
